//--- design/lsq_cfg.svh
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

// queue and core index widths
`define LSQ_SZ        8
`define LSQ_IDX       3
`define ROB_IDX       5
`define PRF_IDX       6

// memory side
`define NUM_MEM_TAGS  7   // tickets 1..7, zero means none
`define MEM_LAT       4   // cycles from ticket grant to reply
`define MEM_WORDS     64

`endif

//--- design/core_pkg.sv
`default_nettype none
`include "lsq_cfg.svh"

package core_pkg;

	typedef logic [`ROB_IDX-1:0] rob_idx_t;
	typedef logic [`PRF_IDX-1:0] prf_idx_t;
	typedef logic [`LSQ_IDX-1:0] lsq_idx_t;
	typedef logic [63:0]         word_t;
	typedef logic [31:0]         inst_t;

	// one dispatch lane, allocation when rd_mem or wr_mem
	typedef struct packed {
		logic     rd_mem;
		logic     wr_mem;
		rob_idx_t rob_idx;
		prf_idx_t pdest_idx;
		word_t    npc;
		inst_t    ir;
	} dispatch_slot_t;

	// address and store data from execute
	typedef struct packed {
		logic     up_req;
		lsq_idx_t lsq_idx;
		word_t    addr;
		word_t    regv;
	} ex_update_t;

	typedef struct packed {
		logic     valid;
		rob_idx_t rob_idx;
		prf_idx_t pdest_idx;
		word_t    value; // store data or loaded data
		logic     rd_mem;
		logic     wr_mem;
		word_t    npc;
		inst_t    ir;
	} commit_slot_t;

endpackage

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

	typedef logic [3:0] mem_tag_t; // zero means no ticket

	typedef enum logic [1:0] {
		BUS_NONE  = 2'd0,
		BUS_LOAD  = 2'd1,
		BUS_STORE = 2'd2
	} bus_cmd_e;

	typedef struct packed {
		bus_cmd_e        cmd;
		core_pkg::word_t addr;
		core_pkg::word_t data;
	} mem_req_t;

	typedef struct packed {
		logic            valid;
		mem_tag_t        tag;
		core_pkg::word_t data;
	} mem_reply_t;

endpackage

`default_nettype wire

//--- design/lsq.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_cfg.svh"

module lsq (
	input  logic                           clk,
	input  logic                           reset,
	input  core_pkg::dispatch_slot_t [1:0] dispatch,
	input  core_pkg::ex_update_t [1:0]     update,
	input  core_pkg::rob_idx_t             rob_head,
	input  mem_pkg::mem_tag_t              mem_ticket,
	input  mem_pkg::mem_reply_t            mem_reply,
	output logic                           full,
	output logic                           full_almost,
	output core_pkg::lsq_idx_t [1:0]       lsq_idx_out,
	output core_pkg::commit_slot_t [1:0]   commit,
	output mem_pkg::mem_req_t              mem_req
);

	localparam int CW = `LSQ_IDX + 1; // occupancy counter width

	// per-entry storage
	core_pkg::word_t    addr      [`LSQ_SZ];
	core_pkg::word_t    value     [`LSQ_SZ]; // store data, later load data
	core_pkg::rob_idx_t rob_idx   [`LSQ_SZ];
	core_pkg::prf_idx_t pdest_idx [`LSQ_SZ];
	core_pkg::word_t    npc       [`LSQ_SZ];
	core_pkg::inst_t    ir        [`LSQ_SZ];
	logic [`LSQ_SZ-1:0] is_store;
	logic [`LSQ_SZ-1:0] launched;
	logic [`LSQ_SZ-1:0] ready_launch; // address known
	logic [`LSQ_SZ-1:0] ready_commit; // load data back

	core_pkg::lsq_idx_t lsq_map [1:`NUM_MEM_TAGS]; // ticket to entry

	core_pkg::lsq_idx_t head, tail;
	core_pkg::lsq_idx_t head_p1, head_p2, tail_p1, tail_p2;
	logic [CW-1:0]      count, next_count, in_cnt, out_cnt;
	logic               empty;

	logic                     req0, req1, acc0, acc1;
	logic [1:0]               alloc_en;
	core_pkg::lsq_idx_t       alloc_idx  [2];
	core_pkg::dispatch_slot_t alloc_slot [2];

	logic launch, stall, load_go, reply_hit;
	logic commit0, commit1;

	assign head_p1 = head + core_pkg::lsq_idx_t'(1);
	assign head_p2 = head + core_pkg::lsq_idx_t'(2);
	assign tail_p1 = tail + core_pkg::lsq_idx_t'(1);
	assign tail_p2 = tail + core_pkg::lsq_idx_t'(2);
	assign empty   = (count == '0);

	// ======================================================================
	// dispatch side
	// ======================================================================
	assign req0 = dispatch[0].rd_mem || dispatch[0].wr_mem;
	assign req1 = dispatch[1].rd_mem || dispatch[1].wr_mem;
	assign acc0 = req0 && !full;
	assign acc1 = acc0 ? (req1 && !full_almost) : (req1 && !full);

	// lane 0 of the write port always lands at tail
	assign alloc_en[0]   = acc0 || acc1;
	assign alloc_idx[0]  = tail;
	assign alloc_slot[0] = acc0 ? dispatch[0] : dispatch[1];
	assign alloc_en[1]   = acc0 && acc1;
	assign alloc_idx[1]  = tail_p1;
	assign alloc_slot[1] = dispatch[1];

	assign lsq_idx_out[0] = tail;
	assign lsq_idx_out[1] = (acc1 && !acc0) ? tail : tail_p1; // lone slot 1 takes tail

	// ======================================================================
	// head launch and commit
	// ======================================================================
	// stores wait for the ROB, loads only need the address
	assign launch = !empty && !launched[head] && ready_launch[head] &&
		(is_store[head] ? (rob_idx[head] == rob_head) : 1'b1);

	assign stall     = launch && !is_store[head] && (mem_ticket == '0); // no free ticket
	assign load_go   = launch && !is_store[head] && !stall;
	assign reply_hit = mem_reply.valid && (mem_reply.tag != '0);

	always_comb begin
		mem_req.cmd = mem_pkg::BUS_NONE;
		if (launch)
			mem_req.cmd = is_store[head] ? mem_pkg::BUS_STORE : mem_pkg::BUS_LOAD;
		mem_req.addr = addr[head];
		mem_req.data = value[head];
	end

	assign commit0 = !empty && (is_store[head] ? launch : ready_commit[head]);
	assign commit1 = commit0 && (count > CW'(1)) &&
		!is_store[head_p1] && ready_commit[head_p1];

	always_comb begin
		core_pkg::lsq_idx_t cidx [2];
		cidx[0] = head;
		cidx[1] = head_p1;
		for (int s = 0; s < 2; s++) begin
			commit[s].valid     = (s == 0) ? commit0 : commit1;
			commit[s].rob_idx   = rob_idx[cidx[s]];
			commit[s].pdest_idx = pdest_idx[cidx[s]];
			commit[s].value     = value[cidx[s]];
			commit[s].rd_mem    = !is_store[cidx[s]];
			commit[s].wr_mem    = is_store[cidx[s]];
			commit[s].npc       = npc[cidx[s]];
			commit[s].ir        = ir[cidx[s]];
		end
	end

	// occupancy bookkeeping
	assign in_cnt     = CW'(acc0) + CW'(acc1);
	assign out_cnt    = CW'(commit0) + CW'(commit1);
	assign next_count = count + in_cnt - out_cnt;

	// ======================================================================
	// state update
	// ======================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			full         <= 1'b0;
			full_almost  <= 1'b0;
			is_store     <= '0;
			launched     <= '0;
			ready_launch <= '0;
			ready_commit <= '0;
		end else begin
			if (commit1)
				head <= head_p2;
			else if (commit0)
				head <= head_p1;

			if (alloc_en[1])
				tail <= tail_p2;
			else if (alloc_en[0])
				tail <= tail_p1;

			count       <= next_count;
			full        <= (next_count == CW'(`LSQ_SZ));
			full_almost <= (next_count == CW'(`LSQ_SZ - 1));

			// fresh entries start idle
			for (int a = 0; a < 2; a++) begin
				if (alloc_en[a]) begin
					is_store[alloc_idx[a]]     <= alloc_slot[a].wr_mem;
					launched[alloc_idx[a]]     <= 1'b0;
					ready_launch[alloc_idx[a]] <= 1'b0;
					ready_commit[alloc_idx[a]] <= 1'b0;
				end
			end

			for (int u = 0; u < 2; u++)
				if (update[u].up_req)
					ready_launch[update[u].lsq_idx] <= 1'b1;

			if (load_go)
				launched[head] <= 1'b1;
			if (reply_hit)
				ready_commit[lsq_map[mem_reply.tag]] <= 1'b1;
		end
	end

	// payload, written without reset
	always_ff @(posedge clk) begin
		for (int a = 0; a < 2; a++) begin
			if (alloc_en[a]) begin
				rob_idx[alloc_idx[a]]   <= alloc_slot[a].rob_idx;
				pdest_idx[alloc_idx[a]] <= alloc_slot[a].pdest_idx;
				npc[alloc_idx[a]]       <= alloc_slot[a].npc;
				ir[alloc_idx[a]]        <= alloc_slot[a].ir;
			end
		end

		for (int u = 0; u < 2; u++) begin
			if (update[u].up_req) begin
				addr[update[u].lsq_idx]  <= update[u].addr;
				value[update[u].lsq_idx] <= update[u].regv; // store data for stores
			end
		end

		if (load_go)
			lsq_map[mem_ticket] <= head;
		if (reply_hit)
			value[lsq_map[mem_reply.tag]] <= mem_reply.data;
	end

endmodule

`default_nettype wire

//--- design/mem_ticket_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_cfg.svh"

module mem_ticket_unit (
	input  logic                clk,
	input  logic                reset,
	input  mem_pkg::mem_req_t   mem_req,
	output mem_pkg::mem_tag_t   mem_ticket,
	output mem_pkg::mem_reply_t mem_reply
);

	localparam int WIDX  = $clog2(`MEM_WORDS);
	localparam int CNT_W = $clog2(`MEM_LAT + 1);

	core_pkg::word_t mem [`MEM_WORDS];

	// ticket pool, entry 0 unused
	logic [`NUM_MEM_TAGS:1] busy;
	logic [CNT_W-1:0]       cnt   [1:`NUM_MEM_TAGS];
	logic [WIDX-1:0]        raddr [1:`NUM_MEM_TAGS]; // word index captured at grant

	logic [WIDX-1:0]   widx;
	mem_pkg::mem_tag_t done_tag;
	logic              take;

	assign widx = mem_req.addr[3 +: WIDX]; // 8-byte words
	assign take = (mem_req.cmd == mem_pkg::BUS_LOAD) && (mem_ticket != '0);

	// lowest free ticket, offered every cycle
	always_comb begin
		mem_ticket = '0;
		for (int t = `NUM_MEM_TAGS; t >= 1; t--)
			if (!busy[t])
				mem_ticket = mem_pkg::mem_tag_t'(t);
	end

	// lowest expired ticket answers
	always_comb begin
		done_tag = '0;
		for (int t = `NUM_MEM_TAGS; t >= 1; t--)
			if (busy[t] && (cnt[t] == '0))
				done_tag = mem_pkg::mem_tag_t'(t);
	end

	always_comb begin
		mem_reply.valid = (done_tag != '0);
		mem_reply.tag   = done_tag;
		mem_reply.data  = '0;
		if (done_tag != '0)
			mem_reply.data = mem[raddr[done_tag]]; // word as it is now
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
			for (int t = 1; t <= `NUM_MEM_TAGS; t++)
				cnt[t] <= '0;
			for (int w = 0; w < `MEM_WORDS; w++)
				mem[w] <= '0;
		end else begin
			if (mem_req.cmd == mem_pkg::BUS_STORE)
				mem[widx] <= mem_req.data;

			for (int t = 1; t <= `NUM_MEM_TAGS; t++)
				if (busy[t] && (cnt[t] != '0))
					cnt[t] <= cnt[t] - CNT_W'(1);

			if (take) begin
				busy[mem_ticket] <= 1'b1;
				cnt[mem_ticket]  <= CNT_W'(`MEM_LAT - 1);
			end
			if (mem_reply.valid)
				busy[done_tag] <= 1'b0; // ticket free again
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			raddr[mem_ticket] <= widx;
	end

endmodule

`default_nettype wire

//--- design/lsq_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsq_top (
	input  logic                           clk,
	input  logic                           reset,
	input  core_pkg::dispatch_slot_t [1:0] dispatch,
	input  core_pkg::ex_update_t [1:0]     update,
	input  core_pkg::rob_idx_t             rob_head,
	output logic                           full,
	output logic                           full_almost,
	output core_pkg::lsq_idx_t [1:0]       lsq_idx_out,
	output core_pkg::commit_slot_t [1:0]   commit
);

	// queue to memory
	mem_pkg::mem_req_t   mem_req;
	mem_pkg::mem_tag_t   mem_ticket;
	mem_pkg::mem_reply_t mem_reply;

	lsq u_lsq (
		.clk         (clk),
		.reset       (reset),
		.dispatch    (dispatch),
		.update      (update),
		.rob_head    (rob_head),
		.mem_ticket  (mem_ticket),
		.mem_reply   (mem_reply),
		.full        (full),
		.full_almost (full_almost),
		.lsq_idx_out (lsq_idx_out),
		.commit      (commit),
		.mem_req     (mem_req)
	);

	mem_ticket_unit u_mem (
		.clk        (clk),
		.reset      (reset),
		.mem_req    (mem_req),
		.mem_ticket (mem_ticket),
		.mem_reply  (mem_reply)
	);

endmodule

`default_nettype wire

//--- tb/lsq_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_cfg.svh"

module lsq_tb;

	// one memory instruction as the core sees it
	typedef struct packed {
		logic               is_store;
		core_pkg::lsq_idx_t lsq_idx;
		core_pkg::rob_idx_t rob_idx;
		core_pkg::prf_idx_t pdest_idx;
		core_pkg::word_t    addr;
		core_pkg::word_t    data;
		core_pkg::word_t    npc;
		core_pkg::inst_t    ir;
	} record_t;

	logic                           clk;
	logic                           reset;
	core_pkg::dispatch_slot_t [1:0] dispatch;
	core_pkg::ex_update_t [1:0]     update;
	core_pkg::rob_idx_t             rob_head;
	logic                           full;
	logic                           full_almost;
	core_pkg::lsq_idx_t [1:0]       lsq_idx_out;
	core_pkg::commit_slot_t [1:0]   commit;

	record_t            staged [$];  // driven this cycle
	record_t            pending [$]; // oldest first
	record_t            upd_q [$];   // address not sent yet
	core_pkg::word_t    ref_mem [`MEM_WORDS] = '{default: '0};
	logic [31:0]        rng_state = 32'h132a_eeee;
	core_pkg::rob_idx_t next_rob = '0;
	core_pkg::word_t    next_npc = 64'h1000;
	core_pkg::lsq_idx_t tb_tail = '0;
	int                 dispatched = 0;
	int                 committed = 0;
	int                 seen_committed = 0; // snapshot taken at the rising edge
	logic               gate_hold = 1'b0;   // keeps rob_head away from the oldest

	lsq_top dut (
		.clk         (clk),
		.reset       (reset),
		.dispatch    (dispatch),
		.update      (update),
		.rob_head    (rob_head),
		.full        (full),
		.full_almost (full_almost),
		.lsq_idx_out (lsq_idx_out),
		.commit      (commit)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ======================================================================
	// random numbers and the reference model
	// ======================================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic pick_store();
		logic [31:0] v;
		v = next_rand();
		return v[7];
	endfunction

	// expected commit slot, loads read the model as it stands at commit
	function automatic core_pkg::commit_slot_t expected_commit(input record_t r);
		core_pkg::commit_slot_t c;
		c.valid     = 1'b1;
		c.rob_idx   = r.rob_idx;
		c.pdest_idx = r.pdest_idx;
		c.value     = r.is_store ? r.data : ref_mem[r.addr[8:3]];
		c.rd_mem    = !r.is_store;
		c.wr_mem    = r.is_store;
		c.npc       = r.npc;
		c.ir        = r.ir;
		return c;
	endfunction

	function automatic core_pkg::rob_idx_t head_rob();
		return (pending.size() != 0) ? pending[0].rob_idx : next_rob;
	endfunction

	function automatic core_pkg::dispatch_slot_t to_slot(input record_t r);
		core_pkg::dispatch_slot_t s;
		s.rd_mem    = !r.is_store;
		s.wr_mem    = r.is_store;
		s.rob_idx   = r.rob_idx;
		s.pdest_idx = r.pdest_idx;
		s.npc       = r.npc;
		s.ir        = r.ir;
		return s;
	endfunction

	function automatic core_pkg::ex_update_t to_update(input record_t r);
		core_pkg::ex_update_t u;
		u.up_req  = 1'b1;
		u.lsq_idx = r.lsq_idx;
		u.addr    = r.addr;
		u.regv    = r.data;
		return u;
	endfunction

	// ======================================================================
	// compare tasks
	// ======================================================================
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_commit(input string name, input core_pkg::commit_slot_t exp,
			input core_pkg::commit_slot_t act);
		if (act !== exp)
			report_failure($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_idx(input string name, input core_pkg::lsq_idx_t exp,
			input core_pkg::lsq_idx_t act);
		if (act !== exp)
			report_failure($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
	endtask

	// commit monitor, both slots in program order
	always @(negedge clk) begin
		record_t                r;
		core_pkg::commit_slot_t exp;
		if (!reset) begin
			if (commit[1].valid && !commit[0].valid)
				report_failure("commit slot 1 fired while slot 0 was idle");
			for (int s = 0; s < 2; s++) begin
				if (commit[s].valid) begin
					if (pending.size() == 0) begin
						report_failure("a commit appeared with no instruction outstanding");
					end else begin
						r = pending.pop_front();
						exp = expected_commit(r);
						check_commit($sformatf("commit_slot%0d", s), exp, commit[s]);
						if (r.is_store)
							ref_mem[r.addr[8:3]] = r.data; // model follows commit order
						committed++;
					end
				end
			end
		end
	end

	// ======================================================================
	// stimulus tasks
	// ======================================================================
	task automatic drive_cycle(input core_pkg::dispatch_slot_t [1:0] d,
			input core_pkg::ex_update_t [1:0] u);
		@(posedge clk);
		while (staged.size() != 0)
			pending.push_back(staged.pop_front());
		seen_committed = committed;
		dispatch <= d;
		update   <= u;
		rob_head <= gate_hold ? head_rob() + core_pkg::rob_idx_t'(3) : head_rob();
		@(negedge clk);
	endtask

	task automatic new_record(input logic store, output record_t r);
		logic [31:0] a, b, c;
		a = next_rand();
		b = next_rand();
		c = next_rand();
		r = '0;
		r.is_store  = store;
		r.rob_idx   = next_rob;
		r.pdest_idx = core_pkg::prf_idx_t'(a);
		r.addr      = core_pkg::word_t'(c % 32'd6) << 3; // six words, loads hit stores
		r.data      = {a, b};
		r.npc       = next_npc;
		r.ir        = {b[31:7], store ? 7'b0100011 : 7'b0000011};
		next_rob    = next_rob + core_pkg::rob_idx_t'(1);
		next_npc    = next_npc + 64'd4;
	endtask

	task automatic dispatch_ops(input string name, input logic use0, input logic use1,
			input logic st0, input logic st1);
		record_t                        r;
		core_pkg::dispatch_slot_t [1:0] d;
		core_pkg::lsq_idx_t             exp1;
		d = '0;
		exp1 = (use1 && !use0) ? tb_tail : tb_tail + core_pkg::lsq_idx_t'(1);
		if (use0) begin
			new_record(st0, r);
			r.lsq_idx = tb_tail;
			d[0] = to_slot(r);
			staged.push_back(r);
			upd_q.push_back(r);
		end
		if (use1) begin
			new_record(st1, r);
			r.lsq_idx = exp1;
			d[1] = to_slot(r);
			staged.push_back(r);
			upd_q.push_back(r);
		end
		drive_cycle(d, '0);
		check_idx({name, "_idx0"}, tb_tail, lsq_idx_out[0]);
		check_idx({name, "_idx1"}, exp1, lsq_idx_out[1]);
		tb_tail = tb_tail + core_pkg::lsq_idx_t'(use0) + core_pkg::lsq_idx_t'(use1);
		dispatched = dispatched + int'(use0) + int'(use1);
	endtask

	// shuffled, two per cycle
	task automatic send_updates();
		core_pkg::ex_update_t [1:0] u;
		record_t                    tmp;
		int                         j;
		for (int i = upd_q.size() - 1; i > 0; i--) begin
			j = int'(next_rand() % (i + 1));
			tmp = upd_q[i];
			upd_q[i] = upd_q[j];
			upd_q[j] = tmp;
		end
		while (upd_q.size() != 0) begin
			u = '0;
			u[0] = to_update(upd_q.pop_front());
			if (upd_q.size() != 0)
				u[1] = to_update(upd_q.pop_front());
			drive_cycle('0, u);
		end
	endtask

	task automatic wait_room(input string what, input int need);
		int cycles;
		cycles = 0;
		while (dispatched - seen_committed > `LSQ_SZ - need) begin
			if (cycles == 200) begin
				report_failure({"timeout while waiting for ", what});
			end else begin
				drive_cycle('0, '0);
				cycles++;
			end
		end
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		logic [31:0] mode;
		logic        use0, use1;
		reset    = 1'b1;
		dispatch = '0;
		update   = '0;
		rob_head = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		// idle after reset
		for (int c = 0; c < 4; c++) begin
			drive_cycle('0, '0);
			check_bit("reset_full", 1'b0, full);
			check_bit("reset_full_almost", 1'b0, full_almost);
			check_bit("idle_commit0", 1'b0, commit[0].valid);
			check_bit("idle_commit1", 1'b0, commit[1].valid);
			check_idx("reset_idx0", '0, lsq_idx_out[0]);
			check_idx("reset_idx1", core_pkg::lsq_idx_t'(1), lsq_idx_out[1]);
		end

		// fill to seven, then eight, no updates yet
		dispatch_ops("lone_slot1", 1'b0, 1'b1, 1'b0, pick_store());
		for (int p = 0; p < 3; p++)
			dispatch_ops("pair", 1'b1, 1'b1, pick_store(), pick_store());
		drive_cycle('0, '0);
		check_bit("seven_full_almost", 1'b1, full_almost);
		check_bit("seven_full", 1'b0, full);
		dispatch_ops("eighth", 1'b1, 1'b0, pick_store(), 1'b0);
		drive_cycle('0, '0);
		check_bit("eight_full", 1'b1, full);
		check_bit("eight_full_almost", 1'b0, full_almost);
		send_updates();
		wait_room("the full queue to drain", `LSQ_SZ);
		check_bit("drained_full", 1'b0, full);
		check_bit("drained_full_almost", 1'b0, full_almost);

		// store held back by rob_head
		gate_hold = 1'b1;
		dispatch_ops("gate_store", 1'b1, 1'b0, 1'b1, 1'b0);
		send_updates();
		repeat (12) begin
			drive_cycle('0, '0);
			check_bit("store_gate_hold", 1'b0, commit[0].valid);
		end
		gate_hold = 1'b0;
		wait_room("the gated store to commit", `LSQ_SZ);

		// random mix with out of order updates
		for (int b = 0; b < 50; b++) begin
			wait_room("room for a batch", 4);
			for (int k = 0; k < 2; k++) begin
				mode = next_rand();
				use0 = (mode[1:0] != 2'd1);
				use1 = (mode[1:0] != 2'd0);
				dispatch_ops("random", use0, use1, pick_store(), pick_store());
			end
			send_updates();
		end
		wait_room("the final drain", `LSQ_SZ);

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/core_pkg.sv
design/mem_pkg.sv
design/lsq.sv
design/mem_ticket_unit.sv
design/lsq_top.sv
tb/lsq_tb.sv

//--- run.sh
#!/bin/sh
# build and run the load/store queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module lsq_tb -Mdir obj_dir -o lsq_tb_sim

./obj_dir/lsq_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
